// File: source/ramPkg.sv
package ramPkg;

    localparam int dataWidth  = 64;
    localparam int addrWidth  = 32;
    localparam int idxWidth   = 16;
    localparam int idWidth    = 4;
    localparam int lenWidth   = 8;
    localparam int sizeWidth  = 3;
    localparam int burstWidth = 2;
    localparam int strbWidth  = dataWidth / 8;
    localparam int offWidth   = $clog2(strbWidth);
    localparam int memDepth   = 1 << idxWidth;

    // largest size code the bus can carry, 8 bytes.
    localparam int maxSize = offWidth;

    typedef logic [dataWidth-1:0]  dataT;
    typedef logic [addrWidth-1:0]  addrT;
    typedef logic [idxWidth-1:0]   idxT;
    typedef logic [idWidth-1:0]    idT;
    typedef logic [lenWidth-1:0]   lenT;
    typedef logic [sizeWidth-1:0]  sizeT;
    typedef logic [burstWidth-1:0] burstT;
    typedef logic [strbWidth-1:0]  strbT;
    typedef logic [offWidth-1:0]   offT;

    // byte count of one beat, 1 to 8.
    typedef logic [offWidth:0] bytesT;

    // fetch issues one word per beat, beat waits for the last one to leave.
    typedef enum logic [1:0] {
        rdIdle,
        rdFetch,
        rdBeat
    } rdStateT;

    typedef enum logic [1:0] {
        wrIdle,
        wrData,
        wrResp
    } wrStateT;

endpackage

// File: source/ramCtrl.sv
module ramCtrl (
    input  logic          clk,
    input  logic          arstN,
    input  logic          arValid,
    input  ramPkg::idT    arId,
    input  ramPkg::addrT  arAddr,
    input  ramPkg::lenT   arLen,
    input  ramPkg::sizeT  arSize,
    input  ramPkg::burstT arBurst,
    input  logic          awValid,
    input  ramPkg::idT    awId,
    input  ramPkg::addrT  awAddr,
    input  ramPkg::lenT   awLen,
    input  ramPkg::sizeT  awSize,
    input  ramPkg::burstT awBurst,
    input  logic          wValid,
    input  logic          wLast,
    output logic          arReady,
    output logic          rValid,
    output ramPkg::idT    rId,
    output logic          rLast,
    output logic          awReady,
    output logic          wReady,
    output logic          bValid,
    output ramPkg::idT    bId,
    output ramPkg::idxT   rdIdx,
    output ramPkg::offT   rdOff,
    output ramPkg::idxT   wrIdx,
    output ramPkg::offT   wrOff,
    output logic          wrEn
);

    ramPkg::rdStateT rdState;
    ramPkg::wrStateT wrState;
    ramPkg::lenT     rdCount;
    ramPkg::lenT     wrCount;
    ramPkg::offT     rdPos;
    ramPkg::bytesT   rdBytes;
    ramPkg::bytesT   wrBytes;
    logic            rdPend;
    logic            rdPendLast;
    logic [ramPkg::offWidth:0] rdStep;
    logic [ramPkg::offWidth:0] wrStep;
    logic            arTake;
    logic            awTake;
    logic            wTake;
    logic            wDone;

    // top bit set when the next beat starts in the following word.
    function automatic logic [ramPkg::offWidth:0] advance(ramPkg::offT off,
                                                          ramPkg::bytesT bytes);
        return {1'b0, off} + bytes;
    endfunction

    assign arTake = arValid && arReady;
    assign awTake = awValid && awReady;
    assign wTake  = wValid && wReady;
    assign wDone  = wTake && (wLast || wrCount == '0);
    assign rdStep = advance(rdPos, rdBytes);
    assign wrStep = advance(wrOff, wrBytes);

    assign arReady = rdState == ramPkg::rdIdle;
    assign awReady = wrState == ramPkg::wrIdle;
    assign wReady  = wrState == ramPkg::wrData;
    assign bValid  = wrState == ramPkg::wrResp;
    assign wrEn    = wTake;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdState    <= ramPkg::rdIdle;
            rdCount    <= '0;
            rdPend     <= 1'b0;
            rdPendLast <= 1'b0;
            rValid     <= 1'b0;
            rLast      <= 1'b0;
        end else begin
            // memory stage, then aligner stage.
            rdPend     <= rdState == ramPkg::rdFetch;
            rdPendLast <= rdState == ramPkg::rdFetch && rdCount == '0;
            rValid     <= rdPend;
            rLast      <= rdPendLast;
            case (rdState)
                ramPkg::rdIdle: begin
                    if (arTake) begin
                        rdState <= ramPkg::rdFetch;
                        rdCount <= (arBurst == '0) ? '0 : arLen; // fixed type is one beat.
                    end
                end
                ramPkg::rdFetch: begin
                    if (rdCount == '0) begin
                        rdState <= ramPkg::rdBeat;
                    end else begin
                        rdCount <= rdCount - 1'b1;
                    end
                end
                ramPkg::rdBeat: begin
                    if (rLast) begin
                        rdState <= ramPkg::rdIdle;
                    end
                end
                default: rdState <= ramPkg::rdIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (arTake) begin
            rdIdx   <= arAddr[ramPkg::offWidth +: ramPkg::idxWidth];
            rdPos   <= arAddr[ramPkg::offWidth-1:0];
            rdBytes <= ramPkg::bytesT'(1) << arSize;
            rId     <= arId;
        end else if (rdState == ramPkg::rdFetch) begin
            rdIdx <= rdIdx + ramPkg::idxT'(rdStep[ramPkg::offWidth]);
            rdPos <= rdStep[ramPkg::offWidth-1:0];
        end
        rdOff <= rdPos; // follows the word into the memory register.
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrState <= ramPkg::wrIdle;
            wrCount <= '0;
        end else begin
            case (wrState)
                ramPkg::wrIdle: begin
                    if (awTake) begin
                        wrState <= ramPkg::wrData;
                        wrCount <= (awBurst == '0) ? '0 : awLen;
                    end
                end
                ramPkg::wrData: begin
                    if (wDone) begin
                        wrState <= ramPkg::wrResp;
                    end else if (wTake) begin
                        wrCount <= wrCount - 1'b1;
                    end
                end
                ramPkg::wrResp: wrState <= ramPkg::wrIdle;
                default: wrState <= ramPkg::wrIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (awTake) begin
            wrIdx   <= awAddr[ramPkg::offWidth +: ramPkg::idxWidth];
            wrOff   <= awAddr[ramPkg::offWidth-1:0];
            wrBytes <= ramPkg::bytesT'(1) << awSize;
            bId     <= awId;
        end else if (wTake) begin
            wrIdx <= wrIdx + ramPkg::idxT'(wrStep[ramPkg::offWidth]);
            wrOff <= wrStep[ramPkg::offWidth-1:0];
        end
    end

    arSizeLegal: assert property (@(posedge clk) disable iff (!arstN)
        arTake |-> arSize <= ramPkg::maxSize);

    awSizeLegal: assert property (@(posedge clk) disable iff (!arstN)
        awTake |-> awSize <= ramPkg::maxSize);

    // wLast from the master matches the remaining beat count.
    lastMatchesCount: assert property (@(posedge clk) disable iff (!arstN)
        wTake |-> wLast == (wrCount == '0));

endmodule

// File: source/readAligner.sv
module readAligner (
    input  logic         clk,
    input  logic         arstN,
    input  ramPkg::dataT rdWord,
    input  ramPkg::offT  rdOff,
    output ramPkg::dataT rData
);

    logic [ramPkg::offWidth+2:0] shiftBits;

    assign shiftBits = {rdOff, 3'b000};

    // upper lanes keep whatever sits above the beat.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rData <= '0;
        end else begin
            rData <= rdWord >> shiftBits; // addressed byte lands in lane 0.
        end
    end

endmodule

// File: source/writeMerger.sv
module writeMerger (
    input  ramPkg::dataT wData,
    input  ramPkg::strbT wStrb,
    input  ramPkg::offT  wrOff,
    output ramPkg::dataT mergeData,
    output ramPkg::dataT mergeMask
);

    ramPkg::dataT                byteMask;
    logic [ramPkg::offWidth+2:0] shiftBits;

    always_comb begin
        for (int i = 0; i < ramPkg::strbWidth; i++) begin
            byteMask[8*i +: 8] = {8{wStrb[i]}};
        end
    end

    // narrow beats arrive right-justified.
    assign shiftBits = {wrOff, 3'b000};
    assign mergeData = wData << shiftBits;
    assign mergeMask = byteMask << shiftBits;

endmodule

// File: source/wordMemory.sv
module wordMemory (
    input  logic         clk,
    input  ramPkg::idxT  rdIdx,
    input  ramPkg::idxT  wrIdx,
    input  logic         wrEn,
    input  ramPkg::dataT wrData,
    input  ramPkg::dataT wrMask,
    output ramPkg::dataT rdWord
);

    ramPkg::dataT mem [ramPkg::memDepth];

    always_ff @(posedge clk) begin
        rdWord <= mem[rdIdx]; // old word on a same-index write.
        if (wrEn) begin
            mem[wrIdx] <= (mem[wrIdx] & ~wrMask) | (wrData & wrMask);
        end
    end

endmodule

// File: source/axiRam.sv
module axiRam (
    input  logic          clk,
    input  logic          arstN,
    input  logic          arValid,
    input  ramPkg::idT    arId,
    input  ramPkg::addrT  arAddr,
    input  ramPkg::lenT   arLen,
    input  ramPkg::sizeT  arSize,
    input  ramPkg::burstT arBurst,
    output logic          arReady,
    output logic          rValid,
    output ramPkg::idT    rId,
    output ramPkg::dataT  rData,
    output logic          rLast,
    input  logic          awValid,
    input  ramPkg::idT    awId,
    input  ramPkg::addrT  awAddr,
    input  ramPkg::lenT   awLen,
    input  ramPkg::sizeT  awSize,
    input  ramPkg::burstT awBurst,
    input  logic          wValid,
    input  ramPkg::dataT  wData,
    input  ramPkg::strbT  wStrb,
    input  logic          wLast,
    output logic          awReady,
    output logic          wReady,
    output logic          bValid,
    output ramPkg::idT    bId
);

    ramPkg::idxT  rdIdx;
    ramPkg::offT  rdOff;
    ramPkg::idxT  wrIdx;
    ramPkg::offT  wrOff;
    logic         wrEn;
    ramPkg::dataT rdWord;
    ramPkg::dataT mergeData;
    ramPkg::dataT mergeMask;

    ramCtrl i_ramCtrl (
        .clk     (clk),
        .arstN   (arstN),
        .arValid (arValid),
        .arId    (arId),
        .arAddr  (arAddr),
        .arLen   (arLen),
        .arSize  (arSize),
        .arBurst (arBurst),
        .awValid (awValid),
        .awId    (awId),
        .awAddr  (awAddr),
        .awLen   (awLen),
        .awSize  (awSize),
        .awBurst (awBurst),
        .wValid  (wValid),
        .wLast   (wLast),
        .arReady (arReady),
        .rValid  (rValid),
        .rId     (rId),
        .rLast   (rLast),
        .awReady (awReady),
        .wReady  (wReady),
        .bValid  (bValid),
        .bId     (bId),
        .rdIdx   (rdIdx),
        .rdOff   (rdOff),
        .wrIdx   (wrIdx),
        .wrOff   (wrOff),
        .wrEn    (wrEn)
    );

    readAligner i_readAligner (
        .clk    (clk),
        .arstN  (arstN),
        .rdWord (rdWord),
        .rdOff  (rdOff),
        .rData  (rData)
    );

    writeMerger i_writeMerger (
        .wData     (wData),
        .wStrb     (wStrb),
        .wrOff     (wrOff),
        .mergeData (mergeData),
        .mergeMask (mergeMask)
    );

    wordMemory i_wordMemory (
        .clk    (clk),
        .rdIdx  (rdIdx),
        .wrIdx  (wrIdx),
        .wrEn   (wrEn),
        .wrData (mergeData),
        .wrMask (mergeMask),
        .rdWord (rdWord)
    );

    // strobes past the word end would be lost by the shift.
    mergeKeepsBytes: assert property (@(posedge clk) disable iff (!arstN)
        wrEn |-> $countones(mergeMask) == 8 * $countones(wStrb));

endmodule

// File: sim/tbClock.sv
module tbClock (
    output logic clk,
    output logic arstN
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period.
    end

    initial begin
        arstN = 1'b0;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
    end

endmodule

// File: sim/tbChecker.sv
module tbChecker (
    input  logic         clk,
    input  logic         arstN,
    input  logic         arReady,
    input  logic         rValid,
    input  ramPkg::idT   rId,
    input  ramPkg::dataT rData,
    input  logic         rLast,
    input  logic         awReady,
    input  logic         wValid,
    input  logic         wReady,
    input  logic         wLast,
    input  logic         bValid,
    input  ramPkg::idT   bId,
    output int           dataErrors,
    output int           protoErrors
);

    timeunit 1ns;
    timeprecision 1ps;

    ramPkg::dataT expData[$];
    ramPkg::dataT expMask[$];
    ramPkg::idT   expId[$];
    logic         expLast[$];
    ramPkg::idT   respId[$];
    logic         resetChecked;
    logic         lastBeatSeen;
    logic         respSeen;
    logic         respDue;
    ramPkg::dataT mask;

    task automatic expectBeat(input ramPkg::idT id, input ramPkg::dataT data,
                              input ramPkg::dataT byteMask, input logic last);
        expId.push_back(id);
        expData.push_back(data);
        expMask.push_back(byteMask);
        expLast.push_back(last);
    endtask

    task automatic expectResp(input ramPkg::idT id);
        respId.push_back(id);
    endtask

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            dataErrors++;
            $display("FAIL at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic protocolFault(input string what);
        protoErrors++;
        $display("protocol error at %0t ns: %s", $time, what);
    endtask

    task automatic leftoverCheck();
        if (expData.size() != 0 || respId.size() != 0) begin
            protocolFault($sformatf("%0d read beats and %0d write responses never came",
                                    expData.size(), respId.size()));
        end
    endtask

    initial begin
        dataErrors   = 0;
        protoErrors  = 0;
        resetChecked = 1'b0;
        lastBeatSeen = 1'b0;
        respSeen     = 1'b0;
        respDue      = 1'b0;
    end

    always @(posedge clk) begin
        if (arstN) begin
            if (!resetChecked) begin
                compare("arReady", 64'(arReady), 64'(1));
                compare("awReady", 64'(awReady), 64'(1));
                compare("rValid", 64'(rValid), 64'(0));
                compare("wReady", 64'(wReady), 64'(0));
                compare("bValid", 64'(bValid), 64'(0));
                resetChecked = 1'b1;
            end
            if (lastBeatSeen) compare("arReady", 64'(arReady), 64'(1)); // back after rLast.
            if (respSeen) compare("awReady", 64'(awReady), 64'(1));
            if (respDue && !bValid) begin
                protocolFault("no write response one cycle after the last write beat");
            end else if (!respDue && bValid) begin
                protocolFault("write response without a finished write burst");
            end
            if (bValid) begin
                if (respId.size() == 0) protocolFault("write response with none expected");
                else compare("bId", 64'(bId), 64'(respId.pop_front()));
            end
            if (rValid) begin
                if (expData.size() == 0) begin
                    protocolFault("read beat arrived with none expected");
                end else begin
                    mask = expMask.pop_front(); // only the beat's bytes count.
                    compare("rData", rData & mask, expData.pop_front() & mask);
                    compare("rId", 64'(rId), 64'(expId.pop_front()));
                    compare("rLast", 64'(rLast), 64'(expLast.pop_front()));
                end
            end
            lastBeatSeen = rValid && rLast;
            respSeen     = bValid;
            respDue      = wValid && wReady && wLast;
        end
    end

endmodule

// File: sim/tbAxiRam.sv
module tbAxiRam;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int seed         = 32'h48e7;
    localparam int randomRounds = 40;
    localparam int txnCount     = 8 + 3 * randomRounds;
    localparam int clkPeriod    = 100;
    localparam int spanBytes    = 256;

    logic          clk;
    logic          arstN;
    logic          arValid;
    ramPkg::idT    arId;
    ramPkg::addrT  arAddr;
    ramPkg::lenT   arLen;
    ramPkg::sizeT  arSize;
    ramPkg::burstT arBurst;
    logic          arReady;
    logic          rValid;
    ramPkg::idT    rId;
    ramPkg::dataT  rData;
    logic          rLast;
    logic          awValid;
    ramPkg::idT    awId;
    ramPkg::addrT  awAddr;
    ramPkg::lenT   awLen;
    ramPkg::sizeT  awSize;
    ramPkg::burstT awBurst;
    logic          wValid;
    ramPkg::dataT  wData;
    ramPkg::strbT  wStrb;
    logic          wLast;
    logic          awReady;
    logic          wReady;
    logic          bValid;
    ramPkg::idT    bId;
    int            dataErrors;
    int            protoErrors;
    logic [7:0]    model [int]; // byte address to byte.

    tbClock i_clock (.clk(clk), .arstN(arstN));

    axiRam i_axiRam (
        .clk(clk), .arstN(arstN),
        .arValid(arValid), .arId(arId), .arAddr(arAddr), .arLen(arLen),
        .arSize(arSize), .arBurst(arBurst), .arReady(arReady),
        .rValid(rValid), .rId(rId), .rData(rData), .rLast(rLast),
        .awValid(awValid), .awId(awId), .awAddr(awAddr), .awLen(awLen),
        .awSize(awSize), .awBurst(awBurst),
        .wValid(wValid), .wData(wData), .wStrb(wStrb), .wLast(wLast),
        .awReady(awReady), .wReady(wReady), .bValid(bValid), .bId(bId)
    );

    tbChecker i_checker (
        .clk(clk), .arstN(arstN), .arReady(arReady), .rValid(rValid), .rId(rId),
        .rData(rData), .rLast(rLast), .awReady(awReady), .wValid(wValid),
        .wReady(wReady), .wLast(wLast), .bValid(bValid), .bId(bId),
        .dataErrors(dataErrors), .protoErrors(protoErrors)
    );

    // offset moves by the beat size, wrapping into the next word.
    task automatic stepBeat(inout int idx, inout int off, input int bytes);
        off = off + bytes;
        if (off >= 8) begin
            off = off - 8;
            idx = idx + 1;
        end
    endtask

    function automatic int alignedAddr(input int size);
        int a;
        a = $urandom_range(spanBytes - 65, 0);
        return a & ~((1 << size) - 1);
    endfunction

    task automatic writeBurst(input int addr, input int size, input int len, input int burst,
                              input bit fullStrb, input bit gaps);
        int         beats;
        int         bytes;
        int         idx;
        int         off;
        int         gap;
        logic [3:0] id;
        logic [63:0] data;
        logic [7:0] strb;
        beats = (burst == 0) ? 1 : len + 1; // burst type zero is a single beat.
        bytes = 1 << size;
        idx   = addr >> 3;
        off   = addr & 7;
        id    = 4'($urandom);
        awValid <= 1'b1;
        awId    <= id;
        awAddr  <= 32'(addr);
        awLen   <= 8'(len);
        awSize  <= 3'(size);
        awBurst <= 2'(burst);
        @(posedge clk);
        while (!awReady) @(posedge clk);
        awValid <= 1'b0;
        i_checker.expectResp(id);
        for (int b = 0; b < beats; b++) begin
            gap = gaps ? $urandom_range(3, 0) : 0;
            if (gap > 0) begin
                wValid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            data = {$urandom, $urandom};
            strb = fullStrb ? 8'hff : 8'($urandom) & 8'((1 << bytes) - 1);
            wValid <= 1'b1;
            wData  <= data;
            wStrb  <= strb;
            wLast  <= (b == beats - 1);
            @(posedge clk);
            while (!wReady) @(posedge clk);
            for (int j = 0; j < bytes; j++) begin
                if (strb[j]) model[idx * 8 + off + j] = data[8 * j +: 8];
            end
            stepBeat(idx, off, bytes);
        end
        wValid <= 1'b0;
        wLast  <= 1'b0;
        @(posedge clk);
        while (!bValid) @(posedge clk);
    endtask

    task automatic readBurst(input int addr, input int size, input int len, input int burst);
        int          beats;
        int          bytes;
        int          idx;
        int          off;
        logic [3:0]  id;
        logic [63:0] data;
        logic [63:0] mask;
        beats = (burst == 0) ? 1 : len + 1;
        bytes = 1 << size;
        idx   = addr >> 3;
        off   = addr & 7;
        id    = 4'($urandom);
        for (int b = 0; b < beats; b++) begin
            data = '0;
            mask = '0;
            for (int j = 0; j < bytes; j++) begin
                if (model.exists(idx * 8 + off + j)) begin
                    data[8 * j +: 8] = model[idx * 8 + off + j]; // right-justified.
                    mask[8 * j +: 8] = 8'hff;
                end
            end
            i_checker.expectBeat(id, data, mask, b == beats - 1);
            stepBeat(idx, off, bytes);
        end
        arValid <= 1'b1;
        arId    <= id;
        arAddr  <= 32'(addr);
        arLen   <= 8'(len);
        arSize  <= 3'(size);
        arBurst <= 2'(burst);
        @(posedge clk);
        while (!arReady) @(posedge clk);
        arValid <= 1'b0;
        @(posedge clk);
        while (!(rValid && rLast)) @(posedge clk);
    endtask

    initial begin
        int size;
        int len;
        int addr;
        void'($urandom(seed));
        arValid = 1'b0;
        arId    = '0;
        arAddr  = '0;
        arLen   = '0;
        arSize  = '0;
        arBurst = '0;
        awValid = 1'b0;
        awId    = '0;
        awAddr  = '0;
        awLen   = '0;
        awSize  = '0;
        awBurst = '0;
        wValid  = 1'b0;
        wData   = '0;
        wStrb   = '0;
        wLast   = 1'b0;
        @(posedge arstN);
        @(posedge clk);
        // fill the whole span with full words, then read it back.
        for (int w = 0; w < spanBytes / 64; w++) begin
            writeBurst(w * 64, 3, 7, 1, 1'b1, 1'b0);
            readBurst(w * 64, 3, 7, 1);
        end
        for (int r = 0; r < randomRounds; r++) begin
            size = $urandom_range(3, 0);
            len  = $urandom_range(7, 0);
            addr = alignedAddr(size);
            writeBurst(addr, size, len, ($urandom_range(3, 0) == 0) ? 0 : 1, 1'b0,
                       $urandom_range(1, 0) == 1);
            readBurst(addr & ~7, 3, 8, 1); // whole words, neighbours too.
            size = $urandom_range(3, 0);
            len  = $urandom_range(7, 0);
            addr = alignedAddr(size);
            readBurst(addr, size, len, ($urandom_range(3, 0) == 0) ? 0 : 1);
        end
        @(posedge clk);
        @(negedge clk); // checker has seen the cycle after the last beat.
        i_checker.leftoverCheck();
        $display("errors: %0d value, %0d protocol", dataErrors, protoErrors);
        if (dataErrors == 0 && protoErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(txnCount * 40 * clkPeriod);
        $display("watchdog expired before all transactions finished");
        $display("Test failed");
        $finish;
    end

endmodule

// File: filelist.f
source/ramPkg.sv
source/ramCtrl.sv
source/readAligner.sv
source/writeMerger.sv
source/wordMemory.sv
source/axiRam.sv
sim/tbClock.sv
sim/tbChecker.sv
sim/tbAxiRam.sv

// File: run.sh
#!/bin/sh
# compile and run the AXI RAM testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tbAxiRam \
    -f filelist.f -Mdir obj_dir -o tbAxiRam
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tbAxiRam > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$log"; then
    exit 1
fi
exit 0
